// ==== Bender.yml ====
package:
  name: rv_fp_csr_unit

sources:
  - verilog/rv_isa_pkg.sv
  - verilog/rv_fp_pkg.sv
  - verilog/rv_csr_decode.sv
  - verilog/rv_fp_csr.sv
  - verilog/rv_fp_cvt_w_s.sv
  - verilog/rv_fp_csr_unit.sv
  - target: test
    files:
      - testbench/tb_rv_fp_csr_unit.sv

// ==== rv_fp_csr_unit.f ====
verilog/rv_isa_pkg.sv
verilog/rv_fp_pkg.sv
verilog/rv_csr_decode.sv
verilog/rv_fp_csr.sv
verilog/rv_fp_cvt_w_s.sv
verilog/rv_fp_csr_unit.sv
testbench/tb_rv_fp_csr_unit.sv

// ==== testbench/rv_fp_csr_unit_patterns.txt ====
# CSR <instr> <rs1_data> <expected rdata> <expected hit>, all hex
# CVT <operand> <rm> <expected value> <expected flags>, all hex
CSR 001022F3 00000000 00000000 1
CSR 002022F3 00000000 00000000 1
CSR 003022F3 00000000 00000000 1
CSR 001312F3 00000035 00000000 1
CSR 001322F3 0000000A 00000015 1
CSR 001332F3 00000005 0000001F 1
CSR 0021D2F3 DEADBEEF 00000000 1
CSR 002262F3 00000000 00000003 1
CSR 002372F3 00000000 00000007 1
CSR 003022F3 00000000 0000003A 1
CSR 003312F3 FFFFFF45 0000003A 1
CSR 300312F3 FFFFFFFF 00000000 0
CSR 003022F3 00000000 00000045 1
CSR 001FF2F3 00000000 00000005 1
# static rounding modes, back to back
CVT 3FC00000 0 00000002 01
CVT 40200000 0 00000002 01
CVT BFC00000 0 FFFFFFFE 01
CVT 40200000 1 00000002 01
CVT C0200000 2 FFFFFFFD 01
CVT 3FA00000 3 00000002 01
CVT C0200000 4 FFFFFFFD 01
CVT 42280000 0 0000002A 00
CVT 7FC00000 1 7FFFFFFF 10
CVT 7F800000 0 7FFFFFFF 10
CVT FF800000 0 80000000 10
CVT 4F000000 1 7FFFFFFF 10
CVT CF000000 1 80000000 00
CVT 4EFFFFFF 0 7FFFFF80 00
CVT 00000000 0 00000000 00
CVT 3F000000 0 00000000 01
CVT BF000000 4 FFFFFFFF 01
CVT BE800000 3 00000000 01
CVT 3E800000 2 00000000 01
# dynamic mode follows frm, reserved modes give NV
CVT 3FC00000 7 00000001 01
CSR 002252F3 00000000 00000002 1
CVT 40200000 7 00000003 01
CSR 0022D2F3 00000000 00000004 1
CVT 3FC00000 7 00000000 10
CVT 3FC00000 5 00000000 10
CSR 002052F3 00000000 00000005 1
# sticky flags and a write in the same cycle as a flag set
CSR 001022F3 00000000 00000011 1
CSR 001312F3 00000000 00000011 1
CVT 3FC00000 1 00000001 01
CVT 7F800000 1 7FFFFFFF 10
CSR 001312F3 00000004 00000000 1
CSR 001022F3 00000000 00000005 1
CSR 003022F3 00000000 00000015 1
CSR 001332F3 00000010 00000015 1
CSR 001022F3 00000000 00000005 1

// ==== testbench/tb_rv_fp_csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_fp_csr_unit;

  import rv_isa_pkg::*;
  import rv_fp_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int MAX_LINES  = 128;

  logic     clk;
  logic     rst_n;
  logic     instr_valid;
  instr_t   instr;
  xlen_t    rs1_data;
  cvt_req_t cvt_in;
  xlen_t    csr_rdata;
  logic     csr_hit;
  frm_t     frm;
  cvt_rsp_t cvt_out;

  // One entry per pattern line, fields a to d as in the file
  logic        pat_is_cvt [MAX_LINES];
  logic [31:0] pat_a      [MAX_LINES];
  logic [31:0] pat_b      [MAX_LINES];
  logic [31:0] pat_c      [MAX_LINES];
  logic [31:0] pat_d      [MAX_LINES];

  int   n_lines;
  logic loaded;
  int   value_errors;
  int   other_errors;
  int   cycle;

  // Converter results still in flight, with the cycle each one is due
  xlen_t   exp_value_q [$];
  fflags_t exp_flags_q [$];
  int      due_q       [$];

  rv_fp_csr_unit UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rs1_data    (rs1_data),
    .cvt_in      (cvt_in),
    .csr_rdata   (csr_rdata),
    .csr_hit     (csr_hit),
    .frm         (frm),
    .cvt_out     (cvt_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_xlen(input string name, input xlen_t expected, input xlen_t actual);
    if (actual !== expected) begin
      value_errors++;
      $display("[FAIL] %0t ns: %s expected %08h, got %08h", $time, name, expected, actual);
    end
  endtask

  task automatic check_flags(input string name, input fflags_t expected, input fflags_t actual);
    if (actual !== expected) begin
      value_errors++;
      $display("[FAIL] %0t ns: %s expected %05b, got %05b", $time, name, expected, actual);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      value_errors++;
      $display("[FAIL] %0t ns: %s expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  task automatic check_frm(input string name, input frm_t expected, input frm_t actual);
    if (actual !== expected) begin
      value_errors++;
      $display("[FAIL] %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
    end
  endtask

  task automatic load_patterns();
    int                fd;
    int                code;
    int                n;
    logic [8*160-1:0]  line_buf;
    logic [8*8-1:0]    kind;
    logic [31:0]       f_a;
    logic [31:0]       f_b;
    logic [31:0]       f_c;
    logic [31:0]       f_d;
    n_lines = 0;
    fd = $fopen("testbench/rv_fp_csr_unit_patterns.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("Could not open the pattern file");
      return;
    end
    while (!$feof(fd)) begin
      line_buf = '0;
      code = $fgets(line_buf, fd);
      if (code > 0) begin
        kind = '0;
        n = $sscanf(line_buf, "%s %h %h %h %h", kind, f_a, f_b, f_c, f_d);
        // Blank lines and lines led by a lone # carry no pattern
        if (n >= 1 && kind != "#") begin
          if (n == 5 && (kind == "CSR" || kind == "CVT") && n_lines < MAX_LINES) begin
            pat_is_cvt[n_lines] = (kind == "CVT");
            pat_a[n_lines]      = f_a;
            pat_b[n_lines]      = f_b;
            pat_c[n_lines]      = f_c;
            pat_d[n_lines]      = f_d;
            n_lines++;
          end else begin
            other_errors++;
            $display("Pattern line %0d is malformed or the table is full", n_lines);
          end
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_line(input int idx);
    if (pat_is_cvt[idx]) begin
      instr_valid     <= 1'b0;
      cvt_in.valid    <= 1'b1;
      cvt_in.operand  <= pat_a[idx];
      cvt_in.rm       <= pat_b[idx][2:0];
    end else begin
      instr_valid     <= 1'b1;
      instr           <= pat_a[idx];
      rs1_data        <= pat_b[idx];
      cvt_in.valid    <= 1'b0;
    end
  endtask

  task automatic drive_idle();
    instr_valid  <= 1'b0;
    cvt_in.valid <= 1'b0;
  endtask

  // CSR results are combinational, converter results are queued
  task automatic check_line(input int idx);
    csr_addr_t addr;
    addr = pat_a[idx][31:20];
    if (pat_is_cvt[idx]) begin
      exp_value_q.push_back(pat_c[idx]);
      exp_flags_q.push_back(pat_d[idx][4:0]);
      due_q.push_back(cycle + 2);
    end else begin
      check_xlen("csr_rdata", pat_c[idx], csr_rdata);
      check_bit("csr_hit", pat_d[idx][0], csr_hit);
      if (addr == CSR_FRM) begin
        check_frm("frm", pat_c[idx][2:0], frm);
      end else if (addr == CSR_FCSR) begin
        check_frm("frm", pat_c[idx][7:5], frm);
      end
    end
  endtask

  task automatic check_cvt_out(input int now);
    if (cvt_out.valid) begin
      if (due_q.size() == 0 || due_q[0] != now) begin
        other_errors++;
        $display("Converter gave a result at %0t ns with no request due", $time);
      end else begin
        check_xlen("cvt_out.value", exp_value_q.pop_front(), cvt_out.value);
        check_flags("cvt_out.flags", exp_flags_q.pop_front(), cvt_out.flags);
        void'(due_q.pop_front());
      end
    end else if (due_q.size() != 0 && due_q[0] == now) begin
      other_errors++;
      $display("Converter result missing at %0t ns", $time);
      void'(exp_value_q.pop_front());
      void'(exp_flags_q.pop_front());
      void'(due_q.pop_front());
    end
  endtask

  initial begin : watchdog
    int limit_ns;
    wait (loaded === 1'b1);
    limit_ns = (n_lines + 20) * 10 * CLK_PERIOD;
    #(limit_ns);
    $display("Watchdog expired after %0d ns, the test did not complete", limit_ns);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin : main
    int idx;
    rst_n        = 1'b0;
    instr_valid  = 1'b0;
    instr        = '0;
    rs1_data     = '0;
    cvt_in       = '0;
    loaded       = 1'b0;
    value_errors = 0;
    other_errors = 0;
    cycle        = 0;
    load_patterns();
    loaded = 1'b1;

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_frm("frm", RM_RNE, frm);

    // One pattern line per cycle, no gaps
    for (idx = 0; idx < n_lines; idx++) begin
      @(posedge clk);
      drive_line(idx);
      @(negedge clk);
      cycle++;
      check_line(idx);
      check_cvt_out(cycle);
    end

    // Drain the converter, then watch it stay idle
    while (due_q.size() != 0) begin
      @(posedge clk);
      drive_idle();
      @(negedge clk);
      cycle++;
      check_cvt_out(cycle);
    end
    repeat (3) begin
      @(posedge clk);
      drive_idle();
      @(negedge clk);
      cycle++;
      check_cvt_out(cycle);
    end

    $display("Checks done: %0d value mismatches, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/rv_csr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_csr_decode (
  input  logic                instr_valid,
  input  rv_isa_pkg::instr_t  instr,
  input  rv_isa_pkg::xlen_t   rs1_data,
  output rv_fp_pkg::csr_req_t csr_req
);

  import rv_isa_pkg::*;
  import rv_fp_pkg::*;

  funct3_t funct3;
  logic    is_system;
  logic    is_csr;
  logic    is_imm;

  assign funct3    = instr[14:12];
  assign is_system = (instr[6:0] == OPCODE_SYSTEM);

  // ECALL/EBREAK and the reserved code fall to the default
  always_comb begin
    is_csr = 1'b0;
    is_imm = 1'b0;
    case (funct3)
      FUNCT3_CSRRW, FUNCT3_CSRRS, FUNCT3_CSRRC: begin
        is_csr = 1'b1;
      end
      FUNCT3_CSRRWI, FUNCT3_CSRRSI, FUNCT3_CSRRCI: begin
        is_csr = 1'b1;
        is_imm = 1'b1;
      end
      default: is_csr = 1'b0;
    endcase
  end

  assign csr_req.en    = instr_valid && is_system && is_csr;
  assign csr_req.addr  = instr[31:20];
  assign csr_req.op    = funct3;
  // Immediate forms carry zimm in the rs1 field
  assign csr_req.wdata = is_imm ? {27'd0, instr[19:15]} : rs1_data;

  // Immediate forms are the codes with funct3 bit 2 set
  always_comb begin
    if (csr_req.en && funct3[2]) begin
      zimm_zero_ext: assert final (csr_req.wdata[31:5] == 27'd0);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/rv_fp_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_fp_csr (
  input  logic                clk,
  input  logic                rst_n,
  input  rv_fp_pkg::csr_req_t csr_req,
  output rv_isa_pkg::xlen_t   csr_rdata,
  output logic                csr_hit,
  output rv_fp_pkg::frm_t     frm,
  input  logic                flag_set_en,
  input  rv_fp_pkg::fflags_t  flag_set
);

  import rv_isa_pkg::*;
  import rv_fp_pkg::*;

  fflags_t fflags_q;
  frm_t    frm_q;

  assign frm = frm_q;

  // Address match
  logic sel_fflags;
  logic sel_frm;
  logic sel_fcsr;

  assign sel_fflags = (csr_req.addr == CSR_FFLAGS);
  assign sel_frm    = (csr_req.addr == CSR_FRM);
  assign sel_fcsr   = (csr_req.addr == CSR_FCSR);
  assign csr_hit    = sel_fflags || sel_frm || sel_fcsr;

  // Old value, zero padded; misses read zero
  always_comb begin
    csr_rdata = '0;
    if (sel_fflags) begin
      csr_rdata[4:0] = fflags_q;
    end else if (sel_frm) begin
      csr_rdata[2:0] = frm_q;
    end else if (sel_fcsr) begin
      csr_rdata[7:0] = {frm_q, fflags_q};
    end
  end

  logic is_write;
  logic is_set;
  logic is_clear;

  assign is_write = csr_req.op inside {FUNCT3_CSRRW, FUNCT3_CSRRWI};
  assign is_set   = csr_req.op inside {FUNCT3_CSRRS, FUNCT3_CSRRSI};
  assign is_clear = csr_req.op inside {FUNCT3_CSRRC, FUNCT3_CSRRCI};

  logic    fflags_we;
  logic    frm_we;
  fflags_t fflags_src;
  frm_t    frm_src;
  fflags_t fflags_next;
  frm_t    frm_next;

  assign fflags_we  = csr_req.en && (sel_fflags || sel_fcsr);
  assign frm_we     = csr_req.en && (sel_frm || sel_fcsr);
  assign fflags_src = csr_req.wdata[4:0];
  // In fcsr the rounding mode sits above the flags
  assign frm_src    = sel_fcsr ? csr_req.wdata[7:5] : csr_req.wdata[2:0];

  always_comb begin
    fflags_next = fflags_q;
    frm_next    = frm_q;

    if (fflags_we) begin
      if (is_write) begin
        fflags_next = fflags_src;
      end else if (is_set) begin
        fflags_next = fflags_q | fflags_src;
      end else if (is_clear) begin
        fflags_next = fflags_q & ~fflags_src;
      end
    end

    if (frm_we) begin
      if (is_write) begin
        frm_next = frm_src;
      end else if (is_set) begin
        frm_next = frm_q | frm_src;
      end else if (is_clear) begin
        frm_next = frm_q & ~frm_src;
      end
    end

    // Converter flags stick on top of any CSR update
    if (flag_set_en) begin
      fflags_next = fflags_next | flag_set;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fflags_q <= '0;
      frm_q    <= '0;
    end else begin
      fflags_q <= fflags_next;
      frm_q    <= frm_next;
    end
  end

  frm_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    !frm_we |=> $stable(frm_q)
  );

  // Bits only drop through a CSR write or clear
  fflags_sticky: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(fflags_we && !is_set) |=> ((fflags_q & $past(fflags_q)) == $past(fflags_q))
  );

endmodule

`default_nettype wire

// ==== verilog/rv_fp_csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_fp_csr_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                instr_valid,
  input  rv_isa_pkg::instr_t  instr,
  input  rv_isa_pkg::xlen_t   rs1_data,
  input  rv_fp_pkg::cvt_req_t cvt_in,
  output rv_isa_pkg::xlen_t   csr_rdata,
  output logic                csr_hit,
  output rv_fp_pkg::frm_t     frm,
  output rv_fp_pkg::cvt_rsp_t cvt_out
);

  import rv_fp_pkg::*;

  csr_req_t csr_req;

  rv_csr_decode u_decode (
    .instr_valid (instr_valid),
    .instr       (instr),
    .rs1_data    (rs1_data),
    .csr_req     (csr_req)
  );

  // Converter results feed the sticky flags directly
  rv_fp_csr u_csr (
    .clk         (clk),
    .rst_n       (rst_n),
    .csr_req     (csr_req),
    .csr_rdata   (csr_rdata),
    .csr_hit     (csr_hit),
    .frm         (frm),
    .flag_set_en (cvt_out.valid),
    .flag_set    (cvt_out.flags)
  );

  rv_fp_cvt_w_s u_cvt (
    .clk     (clk),
    .rst_n   (rst_n),
    .cvt_in  (cvt_in),
    .frm     (frm),
    .cvt_out (cvt_out)
  );

endmodule

`default_nettype wire

// ==== verilog/rv_fp_cvt_w_s.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_fp_cvt_w_s (
  input  logic                clk,
  input  logic                rst_n,
  input  rv_fp_pkg::cvt_req_t cvt_in,
  input  rv_fp_pkg::frm_t     frm,
  output rv_fp_pkg::cvt_rsp_t cvt_out
);

  import rv_isa_pkg::*;
  import rv_fp_pkg::*;

  // Stage 1 unpack and align
  logic        in_sign;
  logic [7:0]  in_exp;
  logic [23:0] in_sig;
  frm_t        in_rm;
  logic [7:0]  sh_raw;
  logic [5:0]  sh;
  logic [87:0] aligned;

  assign in_sign = cvt_in.operand[31];
  assign in_exp  = cvt_in.operand[30:23];
  // Hidden bit is absent for zero and subnormals
  assign in_sig  = {(in_exp != 8'd0), cvt_in.operand[22:0]};
  assign in_rm   = (cvt_in.rm == RM_DYN) ? frm : cvt_in.rm;

  // Integer part lands in [87:56] with the guard at 55 and sticky bits below
  assign sh_raw  = 8'd158 - in_exp;
  assign sh      = (in_exp >= 8'd95) ? sh_raw[5:0] : 6'd63;
  assign aligned = {in_sig, 64'd0} >> sh;

  logic        s1_valid;
  logic        s1_sign;
  logic [31:0] s1_int;
  logic        s1_guard;
  logic        s1_sticky;
  frm_t        s1_rm;
  logic        s1_nan;
  logic        s1_big;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= cvt_in.valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_sign   <= in_sign;
    s1_int    <= aligned[87:56];
    s1_guard  <= aligned[55];
    s1_sticky <= |aligned[54:0];
    s1_rm     <= in_rm;
    s1_nan    <= (in_exp == 8'hff) && (cvt_in.operand[22:0] != 23'd0);
    // Magnitude of 2^32 and above including infinities
    s1_big    <= (in_exp >= 8'd159);
  end

  // Stage 2 rounds, saturates and sets flags
  logic        inexact;
  logic        round_up;
  logic [32:0] rounded;
  logic        ovf;
  xlen_t       res_value;
  fflags_t     res_flags;

  assign inexact = s1_guard || s1_sticky;

  always_comb begin
    case (s1_rm)
      RM_RNE:  round_up = s1_guard && (s1_sticky || s1_int[0]);
      RM_RTZ:  round_up = 1'b0;
      RM_RDN:  round_up = s1_sign && inexact;
      RM_RUP:  round_up = !s1_sign && inexact;
      RM_RMM:  round_up = s1_guard;
      default: round_up = 1'b0;
    endcase
  end

  assign rounded = {1'b0, s1_int} + {32'd0, round_up};
  // -2^31 is the one magnitude above 2^31-1 that fits
  assign ovf     = s1_sign ? (rounded > 33'h080000000) : (rounded > 33'h07fffffff);

  always_comb begin
    res_value = '0;
    res_flags = '0;
    if (s1_rm > RM_RMM) begin
      res_flags[FLAG_NV] = 1'b1;
    end else if (s1_nan) begin
      res_value          = 32'h7fffffff;
      res_flags[FLAG_NV] = 1'b1;
    end else if (s1_big || ovf) begin
      res_value          = s1_sign ? 32'h80000000 : 32'h7fffffff;
      res_flags[FLAG_NV] = 1'b1;
    end else begin
      res_value          = s1_sign ? (~rounded[31:0] + 32'd1) : rounded[31:0];
      res_flags[FLAG_NX] = inexact;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cvt_out.valid <= 1'b0;
    end else begin
      cvt_out.valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    cvt_out.value <= s1_valid ? res_value : '0;
    cvt_out.flags <= s1_valid ? res_flags : '0;
  end

  valid_latency: assert property (
    @(posedge clk) disable iff (!rst_n)
    cvt_out.valid == $past(cvt_in.valid, 2)
  );

  flags_idle_zero: assert property (
    @(posedge clk) disable iff (!rst_n)
    !cvt_out.valid |-> (cvt_out.flags == '0)
  );

endmodule

`default_nettype wire

// ==== verilog/rv_fp_pkg.sv ====
`default_nettype none

package rv_fp_pkg;

  typedef logic [31:0] fp32_t;
  typedef logic [4:0]  fflags_t;
  typedef logic [2:0]  frm_t;

  // Flag positions, NV at the top down to NX at bit 0
  localparam int FLAG_NV = 4;
  localparam int FLAG_DZ = 3;
  localparam int FLAG_OF = 2;
  localparam int FLAG_UF = 1;
  localparam int FLAG_NX = 0;

  // Rounding modes, codes 5 and 6 are reserved
  localparam frm_t RM_RNE = 3'd0;
  localparam frm_t RM_RTZ = 3'd1;
  localparam frm_t RM_RDN = 3'd2;
  localparam frm_t RM_RUP = 3'd3;
  localparam frm_t RM_RMM = 3'd4;
  localparam frm_t RM_DYN = 3'd7;

  // Decoded CSR access
  typedef struct packed {
    logic                  en;
    rv_isa_pkg::csr_addr_t addr;
    rv_isa_pkg::funct3_t   op;
    rv_isa_pkg::xlen_t     wdata;
  } csr_req_t;

  // FCVT.W.S request and result
  typedef struct packed {
    logic  valid;
    fp32_t operand;
    frm_t  rm;
  } cvt_req_t;

  typedef struct packed {
    logic              valid;
    rv_isa_pkg::xlen_t value;
    fflags_t           flags;
  } cvt_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

  // Instruction fields and register widths
  typedef logic [11:0] csr_addr_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [31:0] instr_t;
  typedef logic [31:0] xlen_t;

  // Floating-point CSR addresses
  localparam csr_addr_t CSR_FFLAGS = 12'h001;
  localparam csr_addr_t CSR_FRM    = 12'h002;
  localparam csr_addr_t CSR_FCSR   = 12'h003;

  // SYSTEM major opcode
  localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

  // CSR access codes in funct3
  // Code 0 is ECALL/EBREAK and code 4 is reserved
  localparam funct3_t FUNCT3_CSRRW  = 3'b001;
  localparam funct3_t FUNCT3_CSRRS  = 3'b010;
  localparam funct3_t FUNCT3_CSRRC  = 3'b011;
  localparam funct3_t FUNCT3_CSRRWI = 3'b101;
  localparam funct3_t FUNCT3_CSRRSI = 3'b110;
  localparam funct3_t FUNCT3_CSRRCI = 3'b111;

endpackage

`default_nettype wire
